//--- source/pgwr_macros.svh
// page-write manager constants
// table placement, entry counts and field widths
`ifndef PGWR_MACROS_SVH
`define PGWR_MACROS_SVH

// byte base of the address-translation table
`define PGWR_ATT_START 64'h0000_0000_0001_0000
// byte base of the list table
`define PGWR_LIST_START 64'h0000_0000_0002_0000
// first physical page number handed to list entries
`define PGWR_PPA_START 48'h0000_0010_0000

`define PGWR_ATT_CNT 32 // att entries
`define PGWR_LIST_CNT 16 // list entries

// pointer and att id width
// zero is the null pointer so ids start at 1
`define PGWR_PTR_W 24
`define PGWR_WAY_W 48 // page way
`define PGWR_ZPD_W 14 // zero-page count in an att entry

`define PGWR_LINE_BYTES 64 // one cache line per write beat

`endif

//--- source/pgwr_pkg.sv
// page-write manager types
// table entry layouts and the encodings used across the design
`include "pgwr_macros.svh"

package pgwr_pkg;

	// att entry status
	typedef enum logic [1:0] {
		STS_DALLOC = 2'd0, // not allocated
		STS_UNCOMP = 2'd1,
		STS_COMP   = 2'd2
	} att_sts_e;

	// list selector of an update
	typedef enum logic [1:0] {
		LST_FREE   = 2'd0,
		LST_UNCOMP = 2'd1,
		LST_NONE   = 2'd2 // entry leaves every list
	} list_sel_e;

	// one table write
	typedef enum logic [2:0] {
		ATT_INIT  = 3'd0,
		LIST_INIT = 3'd1,
		ATT_SET   = 3'd2,
		POP_HEAD  = 3'd3, // null the prev of the new head
		PUSH_TAIL = 3'd4, // moved entry gets old tail as prev
		LINK_TAIL = 3'd5, // old tail next points to moved entry
		NULLIFY   = 3'd6
	} step_e;

	// 64 bit att entry with status in the low bits
	typedef struct packed {
		logic [`PGWR_ZPD_W-1:0] zpd_cnt; // bits 63:50
		logic [`PGWR_WAY_W-1:0] way;     // bits 49:2
		att_sts_e               sts;     // bits 1:0
	} att_entry_t;

	// 128 bit list entry
	typedef struct packed {
		logic [7:0]             rsvd;
		logic [`PGWR_WAY_W-1:0] way;
		logic [`PGWR_PTR_W-1:0] att_id;
		logic [`PGWR_PTR_W-1:0] prev;
		logic [`PGWR_PTR_W-1:0] next; // bytes 2:0 of the lane
	} list_entry_t;

	// one write-data line seen as att lanes or as list lanes
	typedef union packed {
		att_entry_t  [`PGWR_LINE_BYTES/8-1:0]  att;
		list_entry_t [`PGWR_LINE_BYTES/16-1:0] lst;
	} line_u;

endpackage

//--- source/tbl_line_fmt.sv
// table line formatter
// turns a step code into address, lane data and byte strobe of one write
`timescale 1ns/1ps
`include "pgwr_macros.svh"

module tbl_line_fmt import pgwr_pkg::*; (
	input  step_e                        step,
	input  logic [`PGWR_PTR_W-1:0]       ent_idx,
	input  logic [`PGWR_PTR_W-1:0]       upd_att_id,
	input  logic [`PGWR_PTR_W-1:0]       upd_tol_id,
	input  list_sel_e                    upd_src,
	input  list_sel_e                    upd_dst,
	input  logic [`PGWR_PTR_W-1:0]       upd_next,
	input  logic [`PGWR_WAY_W-1:0]       upd_way,
	input  logic [`PGWR_ZPD_W-1:0]       upd_zpd,
	input  logic [`PGWR_PTR_W-1:0]       uncomp_tail,
	output logic [63:0]                  addr,
	output line_u                        data,
	output logic [`PGWR_LINE_BYTES-1:0]  strb
);

	logic [`PGWR_PTR_W-1:0] id;       // entry written by this step
	logic [`PGWR_PTR_W-1:0] idm1;
	logic                   is_att;
	logic [2:0]             att_lane; // 8 att entries per line
	logic [1:0]             lst_lane; // 4 list entries per line
	logic [15:0]            lane_strb;
	att_entry_t             ae;
	list_entry_t            le;

	always_comb begin
		case (step)
			ATT_INIT, LIST_INIT: id = ent_idx;
			ATT_SET:             id = upd_att_id;
			POP_HEAD:            id = upd_next; // new head of the source
			LINK_TAIL:           id = uncomp_tail; // old tail
			default:             id = upd_tol_id;
		endcase
	end

	assign idm1     = id - 1'b1;
	assign is_att   = (step == ATT_INIT) || (step == ATT_SET);
	assign att_lane = idm1[2:0];
	assign lst_lane = idm1[1:0];
	assign addr     = is_att ?
		`PGWR_ATT_START + 64'(idm1[`PGWR_PTR_W-1:3]) * `PGWR_LINE_BYTES :
		`PGWR_LIST_START + 64'(idm1[`PGWR_PTR_W-1:2]) * `PGWR_LINE_BYTES;

	// att lane content
	always_comb begin
		ae     = '0;
		ae.sts = STS_DALLOC; // init value
		if (step == ATT_SET) begin
			ae.way = upd_way;
			if ((upd_src == LST_FREE) && (upd_dst == LST_UNCOMP)) begin
				ae.sts     = STS_UNCOMP;
				ae.zpd_cnt = upd_zpd;
			end else begin
				ae.sts = STS_COMP; // count stays zero
			end
		end
	end

	// list lane content and the bytes it touches
	always_comb begin
		le        = '0;
		lane_strb = '0;
		case (step)
			LIST_INIT: begin
				le.way    = `PGWR_PPA_START + `PGWR_WAY_W'(idm1);
				le.prev   = idm1; // first entry gets null
				le.next   = (ent_idx == `PGWR_PTR_W'(`PGWR_LIST_CNT)) ? '0 : ent_idx + 1'b1;
				lane_strb = 16'hffff;
			end
			POP_HEAD: lane_strb = 16'h0038; // prev bytes only and data stays null
			PUSH_TAIL, NULLIFY: begin
				le.prev   = (step == PUSH_TAIL) ? uncomp_tail : '0;
				le.att_id = upd_att_id;
				lane_strb = 16'h01ff; // next, prev and att id
			end
			LINK_TAIL: begin
				le.next   = upd_tol_id;
				lane_strb = 16'h0007;
			end
			default: lane_strb = '0;
		endcase
	end

	always_comb begin
		data = '0;
		strb = '0;
		if (is_att) begin
			data.att[att_lane]    = ae;
			strb[att_lane*8 +: 8] = 8'hff;
		end else begin
			data.lst[lst_lane]      = le;
			strb[lst_lane*16 +: 16] = lane_strb;
		end
	end

endmodule

//--- source/list_ht_regs.sv
// list head and tail registers
// free and uncompressed list pointers moved by sequencer commands
`timescale 1ns/1ps
`include "pgwr_macros.svh"

module list_ht_regs import pgwr_pkg::*; (
	input  logic                   clk_i,
	input  logic                   rst_ni,
	input  logic                   list_init, // free list built
	input  logic [`PGWR_PTR_W-1:0] list_last,
	input  list_sel_e              src_list,
	input  list_sel_e              dst_list,
	input  logic                   pop_src,
	input  logic                   empty_src,
	input  logic [`PGWR_PTR_W-1:0] new_head,
	input  logic                   push_dst,
	input  logic                   first_dst,
	input  logic [`PGWR_PTR_W-1:0] tol_id,
	output logic [`PGWR_PTR_W-1:0] free_head,
	output logic [`PGWR_PTR_W-1:0] free_tail,
	output logic [`PGWR_PTR_W-1:0] uncomp_head,
	output logic [`PGWR_PTR_W-1:0] uncomp_tail
);

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			free_head   <= '0; // all lists empty
			free_tail   <= '0;
			uncomp_head <= '0;
			uncomp_tail <= '0;
		end else begin
			if (list_init) begin
				free_head <= `PGWR_PTR_W'(1);
				free_tail <= list_last;
			end
			if (pop_src) begin
				if (src_list == LST_UNCOMP) uncomp_head <= new_head;
				else free_head <= new_head;
			end
			if (empty_src) begin // last entry left the source
				if (src_list == LST_UNCOMP) begin
					uncomp_head <= '0;
					uncomp_tail <= '0;
				end else begin
					free_head <= '0;
					free_tail <= '0;
				end
			end
			if (push_dst && (dst_list == LST_UNCOMP)) begin
				uncomp_tail <= tol_id;
				if (first_dst) uncomp_head <= tol_id; // first entry is head too
			end
		end
	end

	a_free_null: assert property (@(posedge clk_i) disable iff (!rst_ni)
		(free_head == '0) == (free_tail == '0));
	a_uncomp_null: assert property (@(posedge clk_i) disable iff (!rst_ni)
		(uncomp_head == '0) == (uncomp_tail == '0));

endmodule

//--- source/axi_wr_port.sv
// AXI write port
// one request at a time with aw then w and a count of outstanding responses
`timescale 1ns/1ps
`include "pgwr_macros.svh"

module axi_wr_port import pgwr_pkg::*; (
	input  logic                         clk_i,
	input  logic                         rst_ni,
	input  logic                         req_load,
	input  logic [63:0]                  addr,
	input  line_u                        data,
	input  logic [`PGWR_LINE_BYTES-1:0]  strb,
	input  logic                         awready,
	input  logic                         wready,
	input  logic                         bvalid,
	input  logic [1:0]                   bresp,
	output logic [63:0]                  awaddr,
	output logic                         awvalid,
	output line_u                        wdata,
	output logic [`PGWR_LINE_BYTES-1:0]  wstrb,
	output logic                         wvalid,
	output logic                         bready,
	output logic                         req_done,
	output logic                         all_resp,
	output logic                         bus_error
);

	logic [7:0] out_cnt; // accepted addresses minus good responses
	logic       aw_hs;
	logic       b_good;

	assign aw_hs    = awvalid && awready;
	assign b_good   = bvalid && (bresp == 2'b00);
	assign req_done = wvalid && wready; // data beat taken
	assign all_resp = (out_cnt == '0);
	assign bready   = 1'b1;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			awvalid   <= 1'b0;
			wvalid    <= 1'b0;
			out_cnt   <= '0;
			bus_error <= 1'b0;
		end else begin
			if (req_load) awvalid <= 1'b1;
			else if (aw_hs) awvalid <= 1'b0;
			if (aw_hs) wvalid <= 1'b1; // w phase starts after the address
			else if (req_done) wvalid <= 1'b0;
			if (aw_hs && !b_good) out_cnt <= out_cnt + 1'b1;
			else if (!aw_hs && b_good) out_cnt <= out_cnt - 1'b1;
			if (bvalid && ((bresp != 2'b00) || (out_cnt == '0))) bus_error <= 1'b1; // sticky
		end
	end

	// payload registers
	always_ff @(posedge clk_i) begin
		if (req_load) begin
			awaddr <= addr;
			wdata  <= data;
			wstrb  <= strb;
		end
	end

	a_aw_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
		awvalid && !awready |=> awvalid);

endmodule

//--- source/pgwr_seq.sv
// page-write sequencer
// walks table init and the update steps one AXI write at a time
`timescale 1ns/1ps
`include "pgwr_macros.svh"

module pgwr_seq import pgwr_pkg::*; (
	input  logic                   clk_i,
	input  logic                   rst_ni,
	input  logic                   init_att,
	input  logic                   init_list,
	input  logic                   upd_valid,
	input  logic [`PGWR_PTR_W-1:0] att_id,
	input  logic [`PGWR_PTR_W-1:0] tol_id,
	input  list_sel_e              src_list,
	input  list_sel_e              dst_list,
	input  logic [`PGWR_PTR_W-1:0] ent_next,
	input  logic [`PGWR_WAY_W-1:0] way,
	input  logic [`PGWR_ZPD_W-1:0] zpd_cnt,
	input  logic [`PGWR_PTR_W-1:0] free_head,
	input  logic [`PGWR_PTR_W-1:0] free_tail,
	input  logic [`PGWR_PTR_W-1:0] uncomp_head,
	input  logic [`PGWR_PTR_W-1:0] uncomp_tail,
	input  logic                   req_done, // data beat accepted
	input  logic                   all_resp, // nothing outstanding
	output step_e                  step,
	output logic [`PGWR_PTR_W-1:0] ent_idx,
	output logic [`PGWR_PTR_W-1:0] upd_att_id,
	output logic [`PGWR_PTR_W-1:0] upd_tol_id,
	output list_sel_e              upd_src,
	output list_sel_e              upd_dst,
	output logic [`PGWR_PTR_W-1:0] upd_next,
	output logic [`PGWR_WAY_W-1:0] upd_way,
	output logic [`PGWR_ZPD_W-1:0] upd_zpd,
	output logic                   req_load,
	output logic                   list_init,
	output logic                   pop_src,
	output logic                   empty_src,
	output logic                   push_dst,
	output logic                   first_dst,
	output logic                   ready,
	output logic                   init_att_done,
	output logic                   init_list_done,
	output logic                   tbl_update_done
);

	typedef enum logic [1:0] {S_IDLE, S_LOAD, S_WAIT, S_RESP} state_e;

	state_e                 state;
	step_e                  step_nxt, dst_step;
	logic                   att_go, list_go, upd_take;
	logic                   wr_done, last_wr, is_init, resp_ok, src_single;
	logic [`PGWR_PTR_W-1:0] src_head, src_tail;

	assign att_go   = init_att && !init_att_done;
	assign list_go  = init_list && !init_list_done && !att_go; // att init goes first
	assign upd_take = (state == S_IDLE) && upd_valid && !att_go && !list_go;

	assign src_head   = (upd_src == LST_UNCOMP) ? uncomp_head : free_head;
	assign src_tail   = (upd_src == LST_UNCOMP) ? uncomp_tail : free_tail;
	assign src_single = (src_head == src_tail); // only the moved entry is left
	assign dst_step   = (upd_dst == LST_NONE) ? NULLIFY : PUSH_TAIL;
	assign first_dst  = (uncomp_tail == '0); // uncomp list empty before the push

	assign wr_done = (state == S_WAIT) && req_done;
	assign is_init = (step == ATT_INIT) || (step == LIST_INIT);
	assign resp_ok = (state == S_RESP) && all_resp;

	// one-cycle commands to the list registers
	assign empty_src = wr_done && (step == ATT_SET) && src_single;
	assign pop_src   = wr_done && (step == POP_HEAD);
	assign push_dst  = wr_done && (((step == PUSH_TAIL) && first_dst) || (step == LINK_TAIL));
	assign list_init = resp_ok && (step == LIST_INIT);

	assign req_load        = (state == S_LOAD);
	assign ready           = (state == S_IDLE);
	assign tbl_update_done = resp_ok && !is_init;

	always_comb begin
		step_nxt = step;
		last_wr  = 1'b0;
		case (step)
			ATT_INIT:  last_wr = (ent_idx == `PGWR_PTR_W'(`PGWR_ATT_CNT));
			LIST_INIT: last_wr = (ent_idx == `PGWR_PTR_W'(`PGWR_LIST_CNT));
			ATT_SET:   step_nxt = src_single ? dst_step : POP_HEAD; // single entry needs no pop
			POP_HEAD:  step_nxt = dst_step;
			PUSH_TAIL: begin
				if (first_dst) last_wr = 1'b1; // no old tail to link
				else step_nxt = LINK_TAIL;
			end
			default:   last_wr = 1'b1; // LINK_TAIL and NULLIFY close the update
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state          <= S_IDLE;
			step           <= ATT_INIT;
			ent_idx        <= '0;
			init_att_done  <= 1'b0;
			init_list_done <= 1'b0;
		end else begin
			case (state)
				S_IDLE: begin
					if (att_go || list_go) begin
						step    <= att_go ? ATT_INIT : LIST_INIT;
						ent_idx <= `PGWR_PTR_W'(1); // ids count from 1
						state   <= S_LOAD;
					end else if (upd_take) begin
						step  <= ATT_SET;
						state <= S_LOAD;
					end
				end
				S_LOAD: state <= S_WAIT; // formatter output goes into the port
				S_WAIT: begin
					if (req_done) begin
						if (last_wr) begin
							state <= S_RESP;
						end else begin
							step  <= step_nxt;
							state <= S_LOAD;
							if (is_init) ent_idx <= ent_idx + 1'b1;
						end
					end
				end
				default: begin
					if (all_resp) begin
						state <= S_IDLE;
						if (step == ATT_INIT) init_att_done <= 1'b1; // sticky
						if (step == LIST_INIT) init_list_done <= 1'b1;
					end
				end
			endcase
		end
	end

	// update request held for the whole walk
	always_ff @(posedge clk_i) begin
		if (upd_take) begin
			upd_att_id <= att_id;
			upd_tol_id <= tol_id;
			upd_src    <= src_list;
			upd_dst    <= dst_list;
			upd_next   <= ent_next;
			upd_way    <= way;
			upd_zpd    <= zpd_cnt;
		end
	end

	// a new request waits for the data beat of the previous one
	a_one_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
		req_load |=> (!req_load until req_done));

endmodule

//--- source/pgwr_mngr_top.sv
// page-write manager top
// sequencer, line formatter, list head/tail registers and AXI write port
`timescale 1ns/1ps
`include "pgwr_macros.svh"

module pgwr_mngr_top import pgwr_pkg::*; (
	input  logic                         clk_i,
	input  logic                         rst_ni,
	input  logic                         init_att, // mode levels
	input  logic                         init_list,
	input  logic                         upd_valid, // update strobe
	input  logic [`PGWR_PTR_W-1:0]       att_id,
	input  logic [`PGWR_PTR_W-1:0]       tol_id,
	input  list_sel_e                    src_list,
	input  list_sel_e                    dst_list,
	input  logic [`PGWR_PTR_W-1:0]       ent_next,
	input  logic [`PGWR_WAY_W-1:0]       way,
	input  logic [`PGWR_ZPD_W-1:0]       zpd_cnt,
	input  logic                         awready,
	input  logic                         wready,
	input  logic                         bvalid,
	input  logic [1:0]                   bresp,
	output logic [63:0]                  awaddr,
	output logic                         awvalid,
	output line_u                        wdata,
	output logic [`PGWR_LINE_BYTES-1:0]  wstrb,
	output logic                         wvalid,
	output logic                         bready,
	output logic                         ready,
	output logic                         init_att_done,
	output logic                         init_list_done,
	output logic                         tbl_update_done,
	output logic                         bus_error,
	output logic [`PGWR_PTR_W-1:0]       free_head,
	output logic [`PGWR_PTR_W-1:0]       free_tail,
	output logic [`PGWR_PTR_W-1:0]       uncomp_head,
	output logic [`PGWR_PTR_W-1:0]       uncomp_tail
);

	step_e                        step;
	logic [`PGWR_PTR_W-1:0]       ent_idx; // init counter and list_last
	logic [`PGWR_PTR_W-1:0]       upd_att_id;
	logic [`PGWR_PTR_W-1:0]       upd_tol_id;
	list_sel_e                    upd_src;
	list_sel_e                    upd_dst;
	logic [`PGWR_PTR_W-1:0]       upd_next;
	logic [`PGWR_WAY_W-1:0]       upd_way;
	logic [`PGWR_ZPD_W-1:0]       upd_zpd;
	logic                         req_load;
	logic                         req_done;
	logic                         all_resp;
	logic                         list_init, pop_src, empty_src, push_dst, first_dst;
	logic [63:0]                  fmt_addr;
	line_u                        fmt_data;
	logic [`PGWR_LINE_BYTES-1:0]  fmt_strb;

	pgwr_seq pgwr_seq_i (.*);

	tbl_line_fmt tbl_line_fmt_i (
		.step, .ent_idx, .upd_att_id, .upd_tol_id, .upd_src, .upd_dst,
		.upd_next, .upd_way, .upd_zpd, .uncomp_tail,
		.addr(fmt_addr), .data(fmt_data), .strb(fmt_strb)
	);

	list_ht_regs list_ht_regs_i (
		.clk_i, .rst_ni, .list_init,
		.list_last(ent_idx), // holds the entry count when list init ends
		.src_list(upd_src), .dst_list(upd_dst), .pop_src, .empty_src,
		.new_head(upd_next), .push_dst, .first_dst, .tol_id(upd_tol_id),
		.free_head, .free_tail, .uncomp_head, .uncomp_tail
	);

	axi_wr_port axi_wr_port_i (
		.clk_i, .rst_ni, .req_load, .addr(fmt_addr), .data(fmt_data), .strb(fmt_strb),
		.awready, .wready, .bvalid, .bresp, .awaddr, .awvalid, .wdata, .wstrb,
		.wvalid, .bready, .req_done, .all_resp, .bus_error
	);

endmodule

//--- verif/pgwr_mngr_tb.sv
// page-write manager testbench
// random-ready AXI slave, reference model of the table writes and list pointers
`timescale 1ns/1ps
`include "pgwr_macros.svh"

module pgwr_mngr_tb import pgwr_pkg::*; ();

	typedef logic [`PGWR_PTR_W-1:0] ptr_t;
	typedef struct packed {
		logic [63:0]                 addr;
		line_u                       data;
		logic [`PGWR_LINE_BYTES-1:0] strb;
	} wr_rec_t;

	localparam int N_WRITES    = `PGWR_ATT_CNT + `PGWR_LIST_CNT + 15; // updates add 15 writes
	localparam int TIMEOUT_CYC = N_WRITES * 200 + 500;

	logic                        clk_i = 1'b0;
	logic                        rst_ni;
	logic                        init_att, init_list, upd_valid;
	ptr_t                        att_id, tol_id, ent_next;
	list_sel_e                   src_list, dst_list;
	logic [`PGWR_WAY_W-1:0]      way;
	logic [`PGWR_ZPD_W-1:0]      zpd_cnt;
	logic                        awready = 1'b0; // slave side
	logic                        wready = 1'b0;
	logic                        bvalid = 1'b0;
	logic [1:0]                  bresp = 2'b00;
	logic [63:0]                 awaddr;
	logic                        awvalid, wvalid, bready;
	line_u                       wdata;
	logic [`PGWR_LINE_BYTES-1:0] wstrb;
	logic                        ready, init_att_done, init_list_done, tbl_update_done;
	logic                        bus_error;
	ptr_t                        free_head, free_tail, uncomp_head, uncomp_tail;

	logic [31:0] lfsr = 32'h4ab6;
	logic [63:0] aw_q[$];   // addresses waiting for their data beat
	int          resp_q[$]; // response delays in cycles
	wr_rec_t     act_q[$];  // writes seen on the bus
	wr_rec_t     exp_q[$];
	string       name_q[$]; // test name per expected write
	bit          inject_err = 1'b0;
	bit          err_sent = 1'b0;
	int          val_errs = 0;
	int          oth_errs = 0;
	int          n_checked = 0;
	int          done_cnt = 0;
	int          exp_done = 0;
	ptr_t        m_free_h, m_free_t, m_unc_h, m_unc_t; // expected list pointers

	pgwr_mngr_top pgwr_mngr_top_i (.*);

	always #5 clk_i = ~clk_i;

	// galois lfsr, one step per bit
	function automatic logic rnd_bit();
		logic b;
		b    = lfsr[0];
		lfsr = lfsr >> 1;
		if (b) lfsr = lfsr ^ 32'h8020_0003;
		return b;
	endfunction

	// expected bus write of one table step
	function automatic wr_rec_t ref_write(step_e st, ptr_t id, ptr_t ptr, ptr_t aid,
		logic [`PGWR_WAY_W-1:0] w, logic [`PGWR_ZPD_W-1:0] z, bit to_unc);
		wr_rec_t     r;
		att_entry_t  ae;
		list_entry_t le;
		int          idx, lo, hi;
		r   = '0;
		ae  = '0;
		le  = '0;
		idx = int'(id) - 1; // ids count from 1
		if (st == ATT_INIT || st == ATT_SET) begin
			r.addr = `PGWR_ATT_START + 64'(idx / 8) * `PGWR_LINE_BYTES; // 8 entries a line
			ae.sts = STS_DALLOC;
			if (st == ATT_SET) begin
				ae.way     = w;
				ae.sts     = to_unc ? STS_UNCOMP : STS_COMP;
				ae.zpd_cnt = to_unc ? z : '0; // compressed entry has no count
			end
			r.data.att[idx % 8] = ae;
			for (int b = 0; b < 8; b++) r.strb[(idx % 8) * 8 + b] = 1'b1;
		end else begin
			r.addr = `PGWR_LIST_START + 64'(idx / 4) * `PGWR_LINE_BYTES;
			lo     = 0;
			hi     = 8; // next, prev and att id
			case (st)
				LIST_INIT: begin
					le.way  = `PGWR_PPA_START + `PGWR_WAY_W'(idx);
					le.prev = ptr_t'(idx);
					le.next = (idx == `PGWR_LIST_CNT - 1) ? '0 : id + 1'b1; // last ends chain
					hi      = 15;
				end
				POP_HEAD: begin
					lo = 3; // prev only, written null
					hi = 5;
				end
				PUSH_TAIL, NULLIFY: begin
					le.prev   = ptr;
					le.att_id = aid;
				end
				default: begin
					le.next = ptr; // link from old tail
					hi      = 2;
				end
			endcase
			r.data.lst[idx % 4] = le;
			for (int b = lo; b <= hi; b++) r.strb[(idx % 4) * 16 + b] = 1'b1;
		end
		return r;
	endfunction

	task automatic check_line(string name, line_u exp, line_u act);
		if (act !== exp) begin
			val_errs++;
			$display("[FAIL] %s data: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_addr(string name, logic [63:0] exp_a, logic [`PGWR_LINE_BYTES-1:0] exp_s,
		logic [63:0] act_a, logic [`PGWR_LINE_BYTES-1:0] act_s);
		if (act_a !== exp_a || act_s !== exp_s) begin
			val_errs++;
			$display("[FAIL] %s addr/strb: expected %h/%h, actual %h/%h",
				name, exp_a, exp_s, act_a, act_s);
		end
	endtask

	task automatic check_ptr(string name, ptr_t exp, ptr_t act);
		if (act !== exp) begin
			val_errs++;
			$display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	task automatic check_flag(string name, logic exp, logic act);
		if (act !== exp) begin
			val_errs++;
			$display("[FAIL] %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic check_lists(string name);
		check_ptr({name, " free_head"}, m_free_h, free_head);
		check_ptr({name, " free_tail"}, m_free_t, free_tail);
		check_ptr({name, " uncomp_head"}, m_unc_h, uncomp_head);
		check_ptr({name, " uncomp_tail"}, m_unc_t, uncomp_tail);
	endtask

	task automatic expect_write(string name, wr_rec_t rec);
		exp_q.push_back(rec);
		name_q.push_back(name);
	endtask

	task automatic check_drained(string name);
		if (exp_q.size() != 0) begin
			oth_errs++;
			$display("%s: %0d expected writes never appeared on the bus", name, exp_q.size());
			exp_q.delete();
			name_q.delete();
		end
	endtask

	task automatic print_counts();
		$display("value errors %0d, other errors %0d, writes checked %0d",
			val_errs, oth_errs, n_checked);
	endtask

	task automatic wait_ready();
		while (!ready) begin
			@(posedge clk_i);
			#1;
		end
	endtask

	// one update request, expected writes and pointer moves from the list rules
	task automatic run_update(string name, ptr_t aid, ptr_t tol, list_sel_e src, list_sel_e dst,
		ptr_t nxt, logic [`PGWR_WAY_W-1:0] w, logic [`PGWR_ZPD_W-1:0] z, bit wait_done);
		ptr_t src_h, src_t;
		bit   single, to_unc;
		src_h  = (src == LST_UNCOMP) ? m_unc_h : m_free_h;
		src_t  = (src == LST_UNCOMP) ? m_unc_t : m_free_t;
		single = (src_h == src_t); // moved entry is the only one
		to_unc = (src == LST_FREE) && (dst == LST_UNCOMP);
		expect_write(name, ref_write(ATT_SET, aid, '0, '0, w, z, to_unc));
		if (!single) expect_write(name, ref_write(POP_HEAD, nxt, '0, '0, '0, '0, 1'b0));
		if (src == LST_UNCOMP) begin
			m_unc_h = single ? '0 : nxt;
			if (single) m_unc_t = '0;
		end else begin
			m_free_h = single ? '0 : nxt;
			if (single) m_free_t = '0;
		end
		if (dst == LST_UNCOMP) begin
			expect_write(name, ref_write(PUSH_TAIL, tol, m_unc_t, aid, '0, '0, 1'b0));
			if (m_unc_t != '0) expect_write(name, ref_write(LINK_TAIL, m_unc_t, tol, '0, '0, '0, 1'b0));
			else m_unc_h = tol; // empty list gets a new head
			m_unc_t = tol;
		end else begin
			expect_write(name, ref_write(NULLIFY, tol, '0, aid, '0, '0, 1'b0));
		end
		wait_ready();
		att_id    = aid;
		tol_id    = tol;
		src_list  = src;
		dst_list  = dst;
		ent_next  = nxt;
		way       = w;
		zpd_cnt   = z;
		upd_valid = 1'b1;
		@(posedge clk_i);
		#1;
		upd_valid = 1'b0; // single-cycle strobe
		if (wait_done) begin
			exp_done++;
			while (!tbl_update_done) begin
				@(posedge clk_i);
				#1;
			end
			@(posedge clk_i);
			#1;
			check_flag({name, " ready"}, 1'b1, ready); // back one cycle after done
		end else begin
			while (exp_q.size() != 0) @(posedge clk_i);
		end
		repeat (3) @(posedge clk_i);
		#1;
		if (done_cnt != exp_done) begin
			oth_errs++;
			$display("%s: tbl_update_done pulsed %0d times in all, %0d expected",
				name, done_cnt, exp_done);
		end
		check_lists(name);
		check_drained(name);
	endtask

	// AXI slave with random ready and response delay
	always @(posedge clk_i) begin
		wr_rec_t rec;
		int      dly;
		bit      live;
		live = rst_ni; // sampled at the edge
		if (live && awvalid && awready) aw_q.push_back(awaddr);
		if (live && wvalid && wready) begin
			if (aw_q.size() == 0) begin
				oth_errs++;
				$display("data beat accepted with no address before it");
			end else begin
				rec.addr = aw_q.pop_front(); // pair beat with its address
				rec.data = wdata;
				rec.strb = wstrb;
				act_q.push_back(rec);
				dly = rnd_bit();
				dly = dly * 2 + rnd_bit(); // 0 to 3 cycles
				resp_q.push_back(dly);
			end
		end
		#1;
		if (!live) begin
			awready = 1'b0;
			wready  = 1'b0;
			bvalid  = 1'b0;
		end else begin
			awready = rnd_bit();
			wready  = rnd_bit();
			if (bvalid && bready) begin
				bvalid = 1'b0;
				bresp  = 2'b00;
			end else if (!bvalid && resp_q.size() != 0) begin
				if (resp_q[0] == 0) begin
					void'(resp_q.pop_front());
					bvalid = 1'b1;
					if (inject_err && !err_sent) begin
						bresp    = 2'b10; // SLVERR once
						err_sent = 1'b1;
					end
				end else begin
					resp_q[0] = resp_q[0] - 1;
				end
			end
		end
	end

	// compare bus writes with the expected ones in order
	always @(negedge clk_i) begin
		wr_rec_t a;
		wr_rec_t e;
		string   nm;
		while (act_q.size() != 0) begin
			a = act_q.pop_front();
			if (exp_q.size() == 0) begin
				oth_errs++;
				$display("unexpected write to address %h", a.addr);
			end else begin
				e  = exp_q.pop_front();
				nm = name_q.pop_front();
				check_addr(nm, e.addr, e.strb, a.addr, a.strb);
				check_line(nm, e.data, a.data);
				n_checked++;
			end
		end
	end

	always @(posedge clk_i) begin
		if (rst_ni && tbl_update_done) done_cnt++;
	end

	// watchdog sized by the number of expected writes
	initial begin
		repeat (TIMEOUT_CYC) @(posedge clk_i);
		$display("timeout after %0d cycles with %0d writes still expected",
			TIMEOUT_CYC, exp_q.size());
		print_counts();
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		rst_ni    = 1'b0;
		init_att  = 1'b0;
		init_list = 1'b0;
		upd_valid = 1'b0;
		att_id    = '0;
		tol_id    = '0;
		src_list  = LST_FREE;
		dst_list  = LST_FREE;
		ent_next  = '0;
		way       = '0;
		zpd_cnt   = '0;
		m_free_h  = '0;
		m_free_t  = '0;
		m_unc_h   = '0;
		m_unc_t   = '0;
		repeat (4) @(posedge clk_i);
		#1;
		rst_ni = 1'b1;

		// outputs right after reset
		check_flag("reset awvalid", 1'b0, awvalid);
		check_flag("reset wvalid", 1'b0, wvalid);
		check_flag("reset bready", 1'b1, bready);
		check_flag("reset ready", 1'b1, ready);
		check_flag("reset att_done", 1'b0, init_att_done);
		check_flag("reset list_done", 1'b0, init_list_done);
		check_flag("reset update_done", 1'b0, tbl_update_done);
		check_flag("reset bus_error", 1'b0, bus_error);
		check_lists("reset");

		// whole ATT written as de-allocated
		for (int i = 1; i <= `PGWR_ATT_CNT; i++)
			expect_write("att_init", ref_write(ATT_INIT, ptr_t'(i), '0, '0, '0, '0, 1'b0));
		init_att = 1'b1; // level, stays high
		while (!init_att_done) begin
			@(posedge clk_i);
			#1;
		end
		check_drained("att_init");

		// one free list over every entry
		for (int i = 1; i <= `PGWR_LIST_CNT; i++)
			expect_write("list_init", ref_write(LIST_INIT, ptr_t'(i), '0, '0, '0, '0, 1'b0));
		init_list = 1'b1;
		while (!init_list_done) begin
			@(posedge clk_i);
			#1;
		end
		m_free_h = ptr_t'(1);
		m_free_t = ptr_t'(`PGWR_LIST_CNT);
		check_lists("list_init");
		check_drained("list_init");

		run_update("free_to_uncomp_first", 5, 1, LST_FREE, LST_UNCOMP, 2,
			48'h0000_0a00_0001, 14'h0123, 1'b1);
		run_update("free_to_uncomp_second", 9, 2, LST_FREE, LST_UNCOMP, 3,
			48'h0000_0b00_0002, 14'h0042, 1'b1);
		run_update("uncomp_pop_to_none", 5, 1, LST_UNCOMP, LST_NONE, 2,
			48'h0000_0c00_0003, 14'h0007, 1'b1);
		run_update("uncomp_single_to_none", 9, 2, LST_UNCOMP, LST_NONE, 0,
			48'h0000_0d00_0004, 14'h0011, 1'b1);
		check_flag("bus_error_clear", 1'b0, bus_error);

		// bad response on the first write of this update
		inject_err = 1'b1;
		run_update("bresp_error", 12, 3, LST_FREE, LST_UNCOMP, 4,
			48'h0000_0e00_0005, 14'h0099, 1'b0);
		check_flag("bus_error_set", 1'b1, bus_error);
		repeat (20) @(posedge clk_i);
		#1;
		check_flag("bus_error_sticky", 1'b1, bus_error);
		check_flag("att_done_sticky", 1'b1, init_att_done);
		check_flag("list_done_sticky", 1'b1, init_list_done);

		print_counts();
		if (val_errs == 0 && oth_errs == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

//--- pgwr_mngr_top.f
+incdir+source
source/pgwr_pkg.sv
source/tbl_line_fmt.sv
source/list_ht_regs.sv
source/axi_wr_port.sv
source/pgwr_seq.sv
source/pgwr_mngr_top.sv
verif/pgwr_mngr_tb.sv

//--- Makefile
# Verilator build and run of the page-write manager testbench
TOP := pgwr_mngr_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f pgwr_mngr_top.f -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee run.log
	grep -q "^ALL CHECKS PASSED$$" run.log

clean:
	rm -rf obj_dir run.log
